//--- design/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and register file
`define RV_XLEN       32
`define RV_REG_COUNT  32

// Memory depths in words
`define RV_IMEM_WORDS 1024
`define RV_DMEM_WORDS 1024

// Fetch sequencing
`define RV_PC_STEP    4    // Bytes per instruction
`define RV_RESET_PC   0

`endif

//--- design/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        alu_src;   // Immediate as operand B
        result_src_t result_src;
        alu_op_t     alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_data, rs2_data, imm;
        word_t     pc, pc_plus4;
        reg_addr_t rd, rs1, rs2;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_t result_src;
        word_t       alu_result, store_data, pc_plus4;
        reg_addr_t   rd;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        result_src_t result_src;
        word_t       alu_result, read_data, pc_plus4;
        reg_addr_t   rd;
    } mem_wb_t;

endpackage

//--- design/rv_hazard_if.sv
interface rv_hazard_if;
    import rv_pkg::*;

    // Source registers in decode and execute
    reg_addr_t rs1_d;
    reg_addr_t rs2_d;
    reg_addr_t rs1_e;
    reg_addr_t rs2_e;

    // Destinations further down the pipe
    reg_addr_t rd_e;
    logic      load_e;
    logic      redirect_e;
    reg_addr_t rd_m;
    logic      reg_write_m;
    reg_addr_t rd_w;
    logic      reg_write_w;

    logic      stall_f;
    logic      stall_d;
    logic      flush_d;
    logic      flush_e;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;

    modport fetch (input stall_f, stall_d, flush_d);
    modport decode (output rs1_d, rs2_d, input flush_e);
    modport execute (output rs1_e, rs2_e, rd_e, load_e, redirect_e, input fwd_a, fwd_b);
    modport memory (output rd_m, reg_write_m, rd_w, reg_write_w);
    modport unit (
        input  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e, redirect_e,
        input  rd_m, reg_write_m, rd_w, reg_write_w,
        output stall_f, stall_d, flush_d, flush_e, fwd_a, fwd_b
    );

endinterface

//--- design/rv_fetch.sv
`include "rv_config.svh"

module rv_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    input  logic               redirect,
    input  rv_pkg::word_t      target,
    rv_hazard_if.fetch         hz,
    output rv_pkg::if_id_t     if_id
);
    import rv_pkg::*;

    localparam int IMEM_AW = $bits(imem_addr_t);

    word_t pc;
    word_t pc_plus4;
    word_t instr;
    word_t imem [`RV_IMEM_WORDS];

    assign pc_plus4 = pc + word_t'(`RV_PC_STEP);
    assign instr    = imem[pc[IMEM_AW+1:2]];   // Word index

    // Program load port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= word_t'(`RV_RESET_PC);
        end else if (redirect) begin
            pc <= target;
        end else if (!hz.stall_f) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id <= '0;
        end else if (hz.flush_d) begin
            if_id <= '0;   // Drop the wrong-path fetch
        end else if (!hz.stall_d) begin
            if_id.instr    <= instr;
            if_id.pc       <= pc;
            if_id.pc_plus4 <= pc_plus4;
        end
    end

endmodule

//--- design/rv_decode.sv
`include "rv_config.svh"

module rv_decode (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::if_id_t    if_id,
    input  logic              wb_write,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    rv_hazard_if.decode       hz,
    output rv_pkg::id_ex_t    id_ex
);
    import rv_pkg::*;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    alu_op_t    arith_op;
    ctrl_t      ctrl;
    word_t      imm;
    logic       wb_valid;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      regs [`RV_REG_COUNT];

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // Register and immediate forms share funct3
    always_comb begin
        case (funct3)
            3'b010:  arith_op = ALU_SLT;
            3'b110:  arith_op = ALU_OR;
            3'b111:  arith_op = ALU_AND;
            default: arith_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = {{20{instr[31]}}, instr[31:20]};   // I-type unless overridden
        case (opcode)
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = RES_MEM;
                ctrl.alu_op     = ALU_ADD;
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;   // Equal when difference is zero
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.result_src = RES_PC4;
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    assign wb_valid = wb_write && (wb_rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Writeback bypass for a read in the same cycle
    assign rs1_data = (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex <= '0;
        end else if (hz.flush_e) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl     <= ctrl;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.pc       <= if_id.pc;
            id_ex.pc_plus4 <= if_id.pc_plus4;
            id_ex.rd       <= rd;
            id_ex.rs1      <= rs1;
            id_ex.rs2      <= rs2;
        end
    end

    assign hz.rs1_d = rs1;
    assign hz.rs2_d = rs2;

endmodule

//--- design/rv_execute.sv
`include "rv_config.svh"

module rv_execute (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::id_ex_t  id_ex,
    input  rv_pkg::word_t   mem_fwd,
    input  rv_pkg::word_t   wb_fwd,
    rv_hazard_if.execute    hz,
    output logic            redirect,
    output rv_pkg::word_t   target,
    output rv_pkg::ex_mem_t ex_mem
);
    import rv_pkg::*;

    localparam int MSB = `RV_XLEN - 1;

    word_t src_a;
    word_t fwd_b_data;
    word_t src_b;
    word_t b_op;
    word_t sum;
    logic  subtract;
    logic  overflow;
    logic  less;
    logic  zero;
    word_t alu_result;

    function automatic word_t fwd_pick(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a      = fwd_pick(hz.fwd_a, id_ex.rs1_data, mem_fwd, wb_fwd);
    assign fwd_b_data = fwd_pick(hz.fwd_b, id_ex.rs2_data, mem_fwd, wb_fwd);
    assign src_b      = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b_data;

    // SUB and SLT add the inverted operand plus one
    assign subtract = id_ex.ctrl.alu_op inside {ALU_SUB, ALU_SLT};
    assign b_op     = subtract ? ~src_b : src_b;
    assign sum      = src_a + b_op + word_t'(subtract);
    assign overflow = ~(src_a[MSB] ^ b_op[MSB]) & (src_a[MSB] ^ sum[MSB]);
    assign less     = sum[MSB] ^ overflow;   // Signed compare

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            ALU_SLT: alu_result = word_t'(less);
            default: alu_result = sum;
        endcase
    end

    assign zero     = (alu_result == '0);
    assign redirect = id_ex.ctrl.jump | (id_ex.ctrl.branch & zero);
    assign target   = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.result_src <= id_ex.ctrl.result_src;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= fwd_b_data;
            ex_mem.pc_plus4   <= id_ex.pc_plus4;
            ex_mem.rd         <= id_ex.rd;
        end
    end

    assign hz.rs1_e      = id_ex.rs1;
    assign hz.rs2_e      = id_ex.rs2;
    assign hz.rd_e       = id_ex.rd;
    assign hz.load_e     = (id_ex.ctrl.result_src == RES_MEM);
    assign hz.redirect_e = redirect;

endmodule

//--- design/rv_memory.sv
`include "rv_config.svh"

module rv_memory (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::ex_mem_t   ex_mem,
    rv_hazard_if.memory       hz,
    output logic              wb_write,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    logic [DMEM_AW-1:0] dmem_addr;
    word_t              read_data;
    mem_wb_t            mem_wb;
    word_t              dmem [`RV_DMEM_WORDS];

    assign dmem_addr = ex_mem.alu_result[DMEM_AW+1:2];   // Word addressed
    assign read_data = dmem[dmem_addr];

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            dmem[dmem_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.result_src <= ex_mem.result_src;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.read_data  <= read_data;
            mem_wb.pc_plus4   <= ex_mem.pc_plus4;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    always_comb begin
        case (mem_wb.result_src)
            RES_MEM: wb_data = mem_wb.read_data;
            RES_PC4: wb_data = mem_wb.pc_plus4;   // JAL link
            default: wb_data = mem_wb.alu_result;
        endcase
    end

    assign wb_write = mem_wb.reg_write;
    assign wb_rd    = mem_wb.rd;

    assign hz.rd_m        = ex_mem.rd;
    assign hz.reg_write_m = ex_mem.reg_write;
    assign hz.rd_w        = mem_wb.rd;
    assign hz.reg_write_w = mem_wb.reg_write;

endmodule

//--- design/rv_hazard_unit.sv
module rv_hazard_unit (
    rv_hazard_if.unit hz
);
    import rv_pkg::*;

    logic load_use;

    // Youngest producer wins
    function automatic fwd_sel_t fwd_pick(
        input reg_addr_t src,
        input logic      wr_m,
        input reg_addr_t rd_m,
        input logic      wr_w,
        input reg_addr_t rd_w
    );
        if (wr_m && rd_m != '0 && rd_m == src) begin
            return FWD_MEM;
        end else if (wr_w && rd_w != '0 && rd_w == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign load_use = hz.load_e && (hz.rd_e != '0) &&
                      (hz.rd_e == hz.rs1_d || hz.rd_e == hz.rs2_d);

    assign hz.stall_f = load_use;
    assign hz.stall_d = load_use;
    assign hz.flush_d = hz.redirect_e;
    assign hz.flush_e = load_use | hz.redirect_e;   // Bubble or wrong path

    assign hz.fwd_a = fwd_pick(hz.rs1_e, hz.reg_write_m, hz.rd_m, hz.reg_write_w, hz.rd_w);
    assign hz.fwd_b = fwd_pick(hz.rs2_e, hz.reg_write_m, hz.rd_m, hz.reg_write_w, hz.rd_w);

endmodule

//--- design/rv_core.sv
module rv_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    output logic               retire_valid,
    output rv_pkg::reg_addr_t  retire_rd,
    output rv_pkg::word_t      retire_data
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    logic      redirect;
    word_t     target;
    logic      wb_write;
    reg_addr_t wb_rd;
    word_t     wb_data;

    rv_hazard_if hz_if ();

    rv_fetch fetch_i (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .redirect   (redirect),
        .target     (target),
        .hz         (hz_if),
        .if_id      (if_id)
    );

    rv_decode decode_i (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .wb_write (wb_write),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .hz       (hz_if),
        .id_ex    (id_ex)
    );

    rv_execute execute_i (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .mem_fwd  (ex_mem.alu_result),
        .wb_fwd   (wb_data),
        .hz       (hz_if),
        .redirect (redirect),
        .target   (target),
        .ex_mem   (ex_mem)
    );

    rv_memory memory_i (
        .clk      (clk),
        .rst      (rst),
        .ex_mem   (ex_mem),
        .hz       (hz_if),
        .wb_write (wb_write),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    rv_hazard_unit hazard_i (
        .hz (hz_if)
    );

    // x0 writes never show as retirements
    assign retire_valid = wb_write && (wb_rd != '0);
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

//--- dv/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int DRIVE_DELAY    = 1;
    localparam int RETIRE_TIMEOUT = 50;    // Cycles allowed per retirement
    localparam int QUIET_CYCLES   = 20;

    logic       clk;
    logic       rst;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_wdata;
    logic       retire_valid;
    reg_addr_t  retire_rd;
    word_t      retire_data;

    word_t     program_words [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    int        checks;
    int        errors;

    rv_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // P lines carry program words, W lines carry expected writes
    task automatic read_tests();
        int           fd;
        int           code;
        int           rd_val;
        logic [7:0]   tag;
        word_t        value;
        logic [959:0] line_buf;
        fd = $fopen("dv/rv_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open dv/rv_tests.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "P") begin
                code = $fscanf(fd, "%h", value);
                if (code == 1) begin
                    program_words.push_back(value);
                end else begin
                    $display("ERROR: program line without a word in the data file");
                    errors++;
                end
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d %h", rd_val, value);
                if (code == 2) begin
                    exp_rd.push_back(reg_addr_t'(rd_val));
                    exp_data.push_back(value);
                end else begin
                    $display("ERROR: expected-write line is incomplete in the data file");
                    errors++;
                end
            end else if (tag == "#") begin
                code = $fgets(line_buf, fd);   // Skip rest of comment
            end else begin
                $display("ERROR: unknown line tag in the data file");
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic load_program();
        foreach (program_words[i]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            imem_we    = 1'b1;
            imem_addr  = imem_addr_t'(i);
            imem_wdata = program_words[i];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        imem_we = 1'b0;
    endtask

    task automatic wait_retire(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);   // Writeback is stable here
            cycles++;
            if (retire_valid) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_retirements();
        bit seen;
        for (int i = 0; i < exp_rd.size(); i++) begin
            wait_retire(seen);
            if (!seen) begin
                $display("ERROR: retirement %0d of x%0d did not arrive within %0d cycles",
                         i, exp_rd[i], RETIRE_TIMEOUT);
                errors++;
                break;
            end
            checks++;
            if (retire_rd !== exp_rd[i]) begin
                $display("CHECK FAILED at %0t: retire_rd expected %0d got %0d",
                         $time, exp_rd[i], retire_rd);
                errors++;
            end
            if (retire_data !== exp_data[i]) begin
                $display("CHECK FAILED at %0t: retire_data expected %h got %h",
                         $time, exp_data[i], retire_data);
                errors++;
            end
        end
    endtask

    // Nothing may retire once the program spins on its last jump
    task automatic check_quiet();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (retire_valid) begin
                $display("ERROR: unexpected retirement of x%0d at %0t", retire_rd, $time);
                errors++;
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        checks     = 0;
        errors     = 0;
        read_tests();
        if (program_words.size() == 0 || exp_rd.size() == 0) begin
            $display("ERROR: the data file holds no program or no expected writes");
            errors++;
        end
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);   // Reset covers the load, then 8 cycles
        #DRIVE_DELAY;
        rst = 1'b0;
        check_retirements();
        check_quiet();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- dv/rv_tests.txt
# P <instruction word, hex>, in address order from 0
# W <rd, decimal> <value, hex>, in retirement order
P 00500093 # addi x1, x0, 5
P ffd00113 # addi x2, x0, -3
P 002081b3 # add  x3, x1, x2   a from WB, b from MEM
P 40118233 # sub  x4, x3, x1   a from MEM
P 003162b3 # or   x5, x2, x3   b from WB
P 0012f333 # and  x6, x5, x1
P 001123b3 # slt  x7, x2, x1
P 0020a433 # slt  x8, x1, x2
P fff12493 # slti x9, x2, -1
P fff0a513 # slti x10, x1, -1
P 0f02f593 # andi x11, x5, 0xf0
P 00f5e613 # ori  x12, x11, 0xf
P 00c02423 # sw   x12, 8(x0)
P 00802683 # lw   x13, 8(x0)
P 00168733 # add  x14, x13, x1   load-use
P 00608663 # beq  x1, x6, +12    taken
P 00100793 # addi x15, x0, 1     skipped
P 00200793 # addi x15, x0, 2     skipped
P 00208463 # beq  x1, x2, +8     not taken
P 00700813 # addi x16, x0, 7
P 00c008ef # jal  x17, +12
P 00100913 # addi x18, x0, 1     skipped
P 00200913 # addi x18, x0, 2     skipped
P 00908013 # addi x0, x1, 9      never retires
P 010889b3 # add  x19, x17, x16
P 0000006f # jal  x0, 0          spin
P 00000013 # nop
P 00000013 # nop
W 1 00000005
W 2 fffffffd
W 3 00000002
W 4 fffffffd
W 5 ffffffff
W 6 00000005
W 7 00000001
W 8 00000000
W 9 00000001
W 10 00000000
W 11 000000f0
W 12 000000ff
W 13 000000ff
W 14 00000104
W 16 00000007
W 17 00000054
W 19 0000005b

//--- tb.f
+incdir+design
design/rv_pkg.sv
design/rv_hazard_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_hazard_unit.sv
design/rv_core.sv
dv/tb_rv_core.sv

//--- Makefile
TOP := tb_rv_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
